//--- rv_decode.f
hw/rv_isa_pkg.sv
hw/decode_pkg.sv
hw/instr_classifier.sv
hw/imm_gen.sv
hw/ctrl_gen.sv
hw/decode_reg.sv
hw/rv_decode_top.sv
sim/rv_decode_assertions.sv
sim/tb_rv_decode.sv

//--- run_sim.sh
#!/bin/sh
# Build the rv_decode testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_rv_decode -f rv_decode.f -o tb_rv_decode > build.log 2>&1 &&
  ./obj_dir/tb_rv_decode > sim.log 2>&1
grep -q "Simulation PASSED" sim.log 2>/dev/null &&
  echo "rv_decode: run passed" && exit 0 ||
  { echo "rv_decode: run failed, see build.log and sim.log"; exit 1; }

//--- sim/rv_decode_trace.txt
// instr valid imm rd rs1 rs2 ctrl, all hex, one instruction per line, expected decode results
// ctrl = {is_system, alu_pc, alu_imm, alu_en, ma_rd, ma_wr, wb_sel[1:0], wb_en, hz_rs1, hz_rs2}
// U format, both signs
123452B7 1 12345000 05 00 03 104 // lui x5, 0x12345
FEDCB0B7 1 FEDCB000 01 00 0D 104 // lui x1, 0xfedcb
80000517 1 80000000 0A 00 00 304 // auipc x10, 0x80000
// J and B formats
001000EF 1 00000800 01 00 01 314 // jal x1, +2048
FFDFF06F 1 FFFFFFFC 00 1F 1D 314 // jal x0, -4
00208863 1 00000010 10 01 02 303 // beq x1, x2, +16
FE419CE3 1 FFFFFFF8 19 03 04 303 // bne x3, x4, -8
// I format
00C12303 1 0000000C 06 02 0C 14E // lw x6, 12(x2)
FFF40393 1 FFFFFFFF 07 08 1F 186 // addi x7, x8, -1
000280E7 1 00000000 01 05 00 116 // jalr x1, 0(x5)
00000073 1 00000000 00 00 00 506 // ecall
305491F3 1 00000305 03 09 05 506 // csrrw x3, 0x305, x9
// S format
00512423 1 00000008 08 02 05 123 // sw x5, 8(x2)
FE638EA3 1 FFFFFFFD 1D 07 06 123 // sb x6, -3(x7)
// R format
003100B3 1 00000000 01 02 03 087 // add x1, x2, x3
40C58533 1 00000000 0A 0B 0C 087 // sub x10, x11, x12
// Idle cycle holds the previous decode
FFFFFFFF 0 00000000 0A 0B 0C 087
// Invalid encodings
00C12301 1 0000000C 06 02 0C 10A // lw with low bits 01
00512420 1 00000008 08 02 05 103 // sw with low bits 00
0FF0000F 1 00000000 00 00 1F 102 // fence, not decoded here
0020850B 1 00000000 0A 01 02 102 // custom-0 opcode
00C12303 0 00000000 0A 01 02 102
// Back to back after an idle cycle
7FF00093 1 000007FF 01 00 1F 186 // addi x1, x0, 2047
00001117 1 00001000 02 00 00 304 // auipc x2, 0x1

//--- sim/tb_rv_decode.sv
module tb_rv_decode;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    CLK_HALF      = 5;
  localparam int    RESET_CYCLES  = 2;
  localparam int    RESET_TIMEOUT = 20;
  localparam string TRACE_PATH    = "sim/rv_decode_trace.txt";

  // Trace layout, one row per instruction
  localparam int N_ROWS      = 24;
  localparam int N_COLS      = 7;
  localparam int TRACE_WORDS = N_ROWS * N_COLS;
  localparam int IDX_W       = $clog2(TRACE_WORDS);

  localparam int COL_INSTR = 0;
  localparam int COL_VALID = 1;
  localparam int COL_IMM   = 2;
  localparam int COL_RD    = 3;
  localparam int COL_RS1   = 4;
  localparam int COL_RS2   = 5;
  localparam int COL_CTRL  = 6;

  logic                        i_clk = 1'b0;
  logic                        i_rst_n;
  logic                        i_valid;
  logic [rv_isa_pkg::ILEN-1:0] i_instr;
  logic                        o_valid;
  decode_pkg::decoded_t        o_dec;

  logic [31:0] trace_mem [0:TRACE_WORDS-1];
  logic [31:0] held_word;
  int          check_count = 0;
  int          error_count = 0;

  rv_decode_top uut (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_instr (i_instr),
    .o_valid (o_valid),
    .o_dec   (o_dec)
  );

  always #CLK_HALF i_clk = ~i_clk;

  // Reset held over two rising edges, released on a falling edge
  initial begin
    i_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] trace_word(input int row, input int col);
    logic [IDX_W-1:0] idx;
    idx = IDX_W'(row * N_COLS + col);
    return trace_mem[idx];
  endfunction

  task automatic check_value(
    input string       name,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    check_count++;
    assert (actual === expected) else begin
      $display("FAILED time %0t: %s expected 0x%08h actual 0x%08h",
               $time, name, expected, actual);
      error_count++;
    end
  endtask

  // Control column carries is_system above the ctrl_t bits
  task automatic check_outputs(
    input logic [31:0] exp_valid,
    input logic [31:0] exp_imm,
    input logic [31:0] exp_rd,
    input logic [31:0] exp_rs1,
    input logic [31:0] exp_rs2,
    input logic [31:0] exp_ctrl
  );
    check_value("o_valid", exp_valid, {31'b0, o_valid});
    check_value("o_dec.immediate", exp_imm, o_dec.immediate);
    check_value("o_dec.fields.rd", exp_rd, {27'b0, o_dec.fields.rd});
    check_value("o_dec.fields.rs1", exp_rs1, {27'b0, o_dec.fields.rs1});
    check_value("o_dec.fields.rs2", exp_rs2, {27'b0, o_dec.fields.rs2});
    check_value("o_dec.ctrl", exp_ctrl, {21'b0, o_dec.is_system, o_dec.ctrl});
  endtask

  // Opcode and function fields sit at fixed RV32I bit positions
  task automatic check_raw_fields(input logic [31:0] word);
    check_value("o_dec.opcode", {27'b0, word[6:2]}, {27'b0, o_dec.opcode});
    check_value("o_dec.fields.funct3", {29'b0, word[14:12]},
                {29'b0, o_dec.fields.funct3});
    check_value("o_dec.fields.funct7", {25'b0, word[31:25]},
                {25'b0, o_dec.fields.funct7});
  endtask

  task automatic check_row(input int row);
    check_outputs(trace_word(row, COL_VALID), trace_word(row, COL_IMM),
                  trace_word(row, COL_RD), trace_word(row, COL_RS1),
                  trace_word(row, COL_RS2), trace_word(row, COL_CTRL));
    check_raw_fields(held_word);
  endtask

  task automatic drive_row(input int row);
    logic [31:0] valid_word;
    valid_word = trace_word(row, COL_VALID);
    i_instr    = trace_word(row, COL_INSTR);
    i_valid    = valid_word[0];
    // o_dec only loads on valid cycles
    if (valid_word[0]) begin
      held_word = i_instr;
    end
  endtask

  task automatic wait_reset_release(output logic timed_out);
    int cycles;
    cycles = 0;
    while (i_rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge i_clk);
      cycles++;
    end
    timed_out = (i_rst_n !== 1'b1);
  endtask

  //////////////////////////////
  // Stimulus and checking
  //////////////////////////////

  initial begin
    int   fd;
    int   row;
    logic timed_out;

    i_valid   = 1'b0;
    i_instr   = '0;
    held_word = '0;

    fd = $fopen(TRACE_PATH, "r");
    if (fd == 0) begin
      $display("Cannot open the trace file %s", TRACE_PATH);
      $display("Simulation FAILED");
      $finish;
    end else begin
      $fclose(fd);
      $readmemh(TRACE_PATH, trace_mem);

      wait_reset_release(timed_out);
      if (timed_out) begin
        $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
        $display("Simulation FAILED");
        $finish;
      end else begin
        // Nothing driven yet, so the stage must still be cleared
        @(negedge i_clk);
        check_outputs(32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0);
        check_raw_fields(32'd0);

        // One row per cycle, each checked one edge after it is driven
        drive_row(0);
        for (row = 1; row < N_ROWS; row++) begin
          @(negedge i_clk);
          check_row(row - 1);
          drive_row(row);
        end
        @(negedge i_clk);
        check_row(N_ROWS - 1);
        i_valid = 1'b0;

        @(negedge i_clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
          $display("Simulation PASSED");
        end else begin
          $display("Simulation FAILED");
        end
        $finish;
      end
    end
  end

endmodule

//--- sim/rv_decode_assertions.sv
module rv_decode_assertions (
  input logic                 i_clk,
  input logic                 i_rst_n,
  input logic                 i_out_valid,
  input decode_pkg::decoded_t i_out_dec
);

  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////
  // Reset
  //////////////////////////////

  a_valid_low_after_reset : assert property (
    @(posedge i_clk) !i_rst_n |=> !i_out_valid
  ) else $error("o_valid high in the cycle after reset");

  //////////////////////////////
  // Control consistency
  //////////////////////////////

  // A load and a store never share one instruction
  a_no_rd_and_wr : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    !(i_out_dec.ctrl.ma_rd && i_out_dec.ctrl.ma_wr)
  ) else $error("ma_rd and ma_wr high together");

  // Stores and branches have no destination register
  a_no_wb_on_store_branch : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_out_dec.ctrl.wb_en |->
      (i_out_dec.opcode != rv_isa_pkg::OP_STORE) &&
      (i_out_dec.opcode != rv_isa_pkg::OP_BRANCH)
  ) else $error("wb_en high for a store or branch");

endmodule

bind rv_decode_top rv_decode_assertions u_assertions (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_out_valid (o_valid),
  .i_out_dec   (o_dec)
);

//--- hw/rv_decode_top.sv
module rv_decode_top (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_valid,
  input  logic [rv_isa_pkg::ILEN-1:0] i_instr,
  output logic                        o_valid,
  output decode_pkg::decoded_t        o_dec
);

  decode_pkg::instr_fields_t   fields;
  rv_isa_pkg::opcode_e         opcode;
  decode_pkg::format_e         format;
  logic                        enc_valid;
  logic [rv_isa_pkg::XLEN-1:0] imm;
  decode_pkg::ctrl_t           ctrl;
  decode_pkg::decoded_t        dec;

  //////////////////////////////
  // Combinational decode
  //////////////////////////////

  instr_classifier u_classifier (
    .i_instr     (i_instr),
    .o_fields    (fields),
    .o_opcode    (opcode),
    .o_format    (format),
    .o_enc_valid (enc_valid)
  );

  imm_gen u_imm_gen (
    .i_instr  (i_instr),
    .i_format (format),
    .o_imm    (imm)
  );

  ctrl_gen u_ctrl_gen (
    .i_opcode    (opcode),
    .i_enc_valid (enc_valid),
    .o_ctrl      (ctrl)
  );

  // Bundle for the stage register
  assign dec.opcode    = opcode;
  assign dec.is_system = (opcode == rv_isa_pkg::OP_SYSTEM);
  assign dec.fields    = fields;
  assign dec.immediate = imm;
  assign dec.ctrl      = ctrl;

  //////////////////////////////
  // Stage register
  //////////////////////////////

  decode_reg u_decode_reg (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_valid),
    .i_dec   (dec),
    .o_valid (o_valid),
    .o_dec   (o_dec)
  );

endmodule

//--- hw/decode_reg.sv
module decode_reg (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_valid,
  input  decode_pkg::decoded_t i_dec,
  output logic                 o_valid,
  output decode_pkg::decoded_t o_dec
);

  //////////////////////////////
  // Stage valid
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  //////////////////////////////
  // Decoded payload
  //////////////////////////////

  // Cleared on reset so all controls start inactive
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_dec <= '0;
    end else if (i_valid) begin
      o_dec <= i_dec;
    end
  end

  // Idle cycles leave the last instruction in place

endmodule

//--- hw/ctrl_gen.sv
module ctrl_gen (
  input  rv_isa_pkg::opcode_e i_opcode,
  input  logic                i_enc_valid,
  output decode_pkg::ctrl_t   o_ctrl
);

  logic op_load;
  logic op_op_imm;
  logic op_auipc;
  logic op_store;
  logic op_op;
  logic op_lui;
  logic op_branch;
  logic op_jalr;
  logic op_jal;

  assign op_load   = (i_opcode == rv_isa_pkg::OP_LOAD);
  assign op_op_imm = (i_opcode == rv_isa_pkg::OP_OP_IMM);
  assign op_auipc  = (i_opcode == rv_isa_pkg::OP_AUIPC);
  assign op_store  = (i_opcode == rv_isa_pkg::OP_STORE);
  assign op_op     = (i_opcode == rv_isa_pkg::OP_OP);
  assign op_lui    = (i_opcode == rv_isa_pkg::OP_LUI);
  assign op_branch = (i_opcode == rv_isa_pkg::OP_BRANCH);
  assign op_jalr   = (i_opcode == rv_isa_pkg::OP_JALR);
  assign op_jal    = (i_opcode == rv_isa_pkg::OP_JAL);

  //////////////////////////////
  // ALU operands
  //////////////////////////////

  // PC-relative targets, JALR bases on rs1 instead
  assign o_ctrl.alu_pc  = op_jal || op_auipc || op_branch;
  assign o_ctrl.alu_imm = !op_op;
  // With alu_en low the ALU just adds
  assign o_ctrl.alu_en  = op_op || op_op_imm;

  //////////////////////////////
  // Memory and write-back
  //////////////////////////////

  // These change architectural state, so a bad encoding must not fire them
  assign o_ctrl.ma_rd = op_load && i_enc_valid;
  assign o_ctrl.ma_wr = op_store && i_enc_valid;
  assign o_ctrl.wb_en = !(op_store || op_branch) && i_enc_valid;

  assign o_ctrl.wb_sel = (op_jal || op_jalr) ? decode_pkg::WB_RET :
                         op_load             ? decode_pkg::WB_MEM :
                                               decode_pkg::WB_ALU;

  // Register read hazards
  assign o_ctrl.hz_rs1 = !(op_lui || op_auipc || op_jal);
  assign o_ctrl.hz_rs2 = op_branch || op_store || op_op;

endmodule

//--- hw/imm_gen.sv
module imm_gen (
  input  logic [rv_isa_pkg::ILEN-1:0] i_instr,
  input  decode_pkg::format_e         i_format,
  output logic [rv_isa_pkg::XLEN-1:0] o_imm
);

  logic [rv_isa_pkg::XLEN-1:0] imm_u;
  logic [rv_isa_pkg::XLEN-1:0] imm_j;
  logic [rv_isa_pkg::XLEN-1:0] imm_b;
  logic [rv_isa_pkg::XLEN-1:0] imm_i;
  logic [rv_isa_pkg::XLEN-1:0] imm_s;

  //////////////////////////////
  // Format layouts
  //////////////////////////////

  // LUI AUIPC
  assign imm_u = {i_instr[31:12], 12'h000};

  // JAL, halfword aligned
  assign imm_j = {
    {12{i_instr[31]}},
    i_instr[19:12],
    i_instr[20],
    i_instr[30:21],
    1'b0
  };

  // Conditional branches, also halfword aligned
  assign imm_b = {
    {20{i_instr[31]}},
    i_instr[7],
    i_instr[30:25],
    i_instr[11:8],
    1'b0
  };

  // Loads, OP-IMM, JALR and SYSTEM
  assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};

  // Stores split the offset around rs2
  assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};

  // Select by format
  always_comb begin
    case (i_format)
      decode_pkg::FMT_U: o_imm = imm_u;
      decode_pkg::FMT_J: o_imm = imm_j;
      decode_pkg::FMT_B: o_imm = imm_b;
      decode_pkg::FMT_I: o_imm = imm_i;
      decode_pkg::FMT_S: o_imm = imm_s;
      // R-type and unknown formats carry no immediate
      default:           o_imm = '0;
    endcase
  end

endmodule

//--- hw/instr_classifier.sv
module instr_classifier (
  input  logic [rv_isa_pkg::ILEN-1:0] i_instr,
  output decode_pkg::instr_fields_t   o_fields,
  output rv_isa_pkg::opcode_e         o_opcode,
  output decode_pkg::format_e         o_format,
  output logic                        o_enc_valid
);

  logic [rv_isa_pkg::OPC_W-1:0] opc_bits;
  rv_isa_pkg::opcode_e          opcode;
  logic                         is_lui;

  //////////////////////////////
  // Opcode
  //////////////////////////////

  assign opc_bits = i_instr[rv_isa_pkg::OPC_LSB +: rv_isa_pkg::OPC_W];

  // Raw bits are kept, unlisted codes are caught by the format
  assign opcode = rv_isa_pkg::opcode_e'(opc_bits);
  assign is_lui = (opcode == rv_isa_pkg::OP_LUI);

  //////////////////////////////
  // Field extraction
  //////////////////////////////

  // LUI has no rs1, so the upper immediate bits must not
  // look like a register read
  assign o_fields.rs1 = i_instr[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_ADDR_W] &
                        {rv_isa_pkg::REG_ADDR_W{!is_lui}};
  assign o_fields.rs2    = i_instr[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_ADDR_W];
  assign o_fields.rd     = i_instr[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_ADDR_W];
  assign o_fields.funct3 = i_instr[rv_isa_pkg::FUNCT3_LSB +: rv_isa_pkg::FUNCT3_W];
  assign o_fields.funct7 = i_instr[rv_isa_pkg::FUNCT7_LSB +: rv_isa_pkg::FUNCT7_W];

  //////////////////////////////
  // Format
  //////////////////////////////

  always_comb begin
    case (opc_bits)
      rv_isa_pkg::OP_LUI,
      rv_isa_pkg::OP_AUIPC:  o_format = decode_pkg::FMT_U;
      rv_isa_pkg::OP_JAL:    o_format = decode_pkg::FMT_J;
      rv_isa_pkg::OP_BRANCH: o_format = decode_pkg::FMT_B;
      rv_isa_pkg::OP_STORE:  o_format = decode_pkg::FMT_S;
      rv_isa_pkg::OP_OP:     o_format = decode_pkg::FMT_R;
      rv_isa_pkg::OP_LOAD,
      rv_isa_pkg::OP_OP_IMM,
      rv_isa_pkg::OP_JALR,
      rv_isa_pkg::OP_SYSTEM: o_format = decode_pkg::FMT_I;
      default:               o_format = decode_pkg::FMT_NONE;
    endcase
  end

  // Only 32-bit encodings of a known opcode are valid
  assign o_enc_valid = (i_instr[1:0] == rv_isa_pkg::LEN_BITS_32) &&
                       (o_format != decode_pkg::FMT_NONE);

  assign o_opcode = opcode;

endmodule

//--- hw/decode_pkg.sv
package decode_pkg;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Immediate layout of an instruction
  typedef enum logic [2:0] {
    FMT_NONE = 3'd0,
    FMT_U    = 3'd1,
    FMT_J    = 3'd2,
    FMT_B    = 3'd3,
    FMT_I    = 3'd4,
    FMT_S    = 3'd5,
    FMT_R    = 3'd6
  } format_e;

  // Write-back source
  //  ALU result, load data or return address (pc + 4)
  typedef enum logic [1:0] {
    WB_ALU = 2'b00,
    WB_MEM = 2'b01,
    WB_RET = 2'b10
  } wb_sel_e;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  // Register and function fields
  typedef struct packed {
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::FUNCT3_W-1:0]   funct3;
    logic [rv_isa_pkg::FUNCT7_W-1:0]   funct7;
  } instr_fields_t;

  // Datapath controls
  typedef struct packed {
    logic    alu_pc;
    logic    alu_imm;
    logic    alu_en;
    logic    ma_rd;
    logic    ma_wr;
    wb_sel_e wb_sel;
    logic    wb_en;
    logic    hz_rs1;
    logic    hz_rs2;
  } ctrl_t;

  // Everything the execute stage needs from one instruction
  typedef struct packed {
    rv_isa_pkg::opcode_e          opcode;
    logic                         is_system;
    instr_fields_t                fields;
    logic [rv_isa_pkg::XLEN-1:0]  immediate;
    ctrl_t                        ctrl;
  } decoded_t;

endpackage

//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

  //////////////////////////////
  // Datapath and field widths
  //////////////////////////////

  // Register, ALU and immediate width
  localparam int XLEN = 32;

  // Base instruction width
  localparam int ILEN = 32;

  localparam int REG_ADDR_W = 5;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;

  // Major opcode without the two length bits
  localparam int OPC_W = 5;

  //////////////////////////////
  // Field positions
  //////////////////////////////

  // LSB of each field inside a base instruction
  localparam int OPC_LSB    = 2;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  // Low two bits of every 32-bit encoding
  localparam logic [1:0] LEN_BITS_32 = 2'b11;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////

  // Codes are inst[6:2] of the RV32I base opcode map
  typedef enum logic [OPC_W-1:0] {
    OP_LOAD   = 5'b00000,
    OP_OP_IMM = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_OP     = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYSTEM = 5'b11100
  } opcode_e;

  // FENCE (MISC-MEM) is not part of this decoder, so its
  // code 00011 falls out as an invalid encoding

endpackage
